// ==== rtl/wb_defines.svh ====
`ifndef WB_DEFINES_SVH
`define WB_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// widths
////////////////////////////////////////////////////////////////////////////

// one data word on the bus
`define WORD_WIDTH 32

// reorder tag
`define TAG_WIDTH 5

`define OP_WIDTH 3

////////////////////////////////////////////////////////////////////////////
// latencies
////////////////////////////////////////////////////////////////////////////

// multiply to bus beat, also the reservation depth, at least 2
`define MUL_LATENCY 4

////////////////////////////////////////////////////////////////////////////
// op codes
////////////////////////////////////////////////////////////////////////////

`define OP_ADD 3'd0
`define OP_SUB 3'd1
`define OP_AND 3'd2
`define OP_OR 3'd3
`define OP_XOR 3'd4
`define OP_SLT 3'd5
`define OP_MUL 3'd6

// owner of a booked beat
`define SRC_ALU 1'b0
`define SRC_MUL 1'b1

`endif

// ==== rtl/issue_pkg.sv ====
`include "wb_defines.svh"

package issue_pkg;

	// data word, both operands and results
	typedef logic [`WORD_WIDTH-1:0] word_t;

	// reorder tag, follows the instruction to its bus beat
	typedef logic [`TAG_WIDTH-1:0] tag_t;

	typedef logic [`OP_WIDTH-1:0] op_t;

	// one instruction on the issue port
	typedef struct packed {
		logic valid;
		op_t op;
		tag_t tag;
		word_t a;
		word_t b;
	} issue_req_t;

endpackage

// ==== rtl/cdb_pkg.sv ====
package cdb_pkg;

	import issue_pkg::*;

	// which unit drives a booked beat
	typedef logic src_t;

	// bus beat, also the shape of an external write
	typedef struct packed {
		logic valid;
		tag_t tag;
		word_t data;
	} cdb_t;

	// one booked bus cycle
	typedef struct packed {
		logic valid;
		tag_t tag;
		src_t src;
	} rsv_slot_t;

endpackage

// ==== rtl/int_alu.sv ====
`timescale 1ns/1ps
`include "wb_defines.svh"

module int_alu (
	input logic clk,
	input logic start,
	input issue_pkg::issue_req_t issue,
	output issue_pkg::word_t result
);
	import issue_pkg::*;

	word_t sum;
	word_t diff;
	logic less;
	word_t alu_value;
	word_t result_q;

	////////////////////////////////////////////////////////////////////////////
	// compute
	////////////////////////////////////////////////////////////////////////////

	assign sum = issue.a + issue.b;
	assign diff = issue.a - issue.b;

	// signed compare for slt
	assign less = $signed(issue.a) < $signed(issue.b);

	always_comb begin
		case (issue.op)
			`OP_ADD: begin
				alu_value = sum;
			end
			`OP_SUB: begin
				alu_value = diff;
			end
			`OP_AND: begin
				alu_value = issue.a & issue.b;
			end
			`OP_OR: begin
				alu_value = issue.a | issue.b;
			end
			`OP_XOR: begin
				alu_value = issue.a ^ issue.b;
			end
			`OP_SLT: begin
				alu_value = {{(`WORD_WIDTH-1){1'b0}}, less};
			end
			default: begin
				alu_value = '0;
			end
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// result register
	////////////////////////////////////////////////////////////////////////////

	// held until the next start, read by the scheduler in the booked cycle
	always_ff @(posedge clk) begin
		if (start) begin
			result_q <= alu_value;
		end
	end

	assign result = result_q;

endmodule

// ==== rtl/mul_pipe.sv ====
`timescale 1ns/1ps
`include "wb_defines.svh"

module mul_pipe (
	input logic clk,
	input logic start,
	input issue_pkg::issue_req_t issue,
	output issue_pkg::word_t result
);
	import issue_pkg::*;

	localparam int STAGES = `MUL_LATENCY - 1;

	word_t a_q;
	word_t b_q;
	logic [2*`WORD_WIDTH-1:0] full_product;
	word_t product;
	word_t stage [STAGES];

	////////////////////////////////////////////////////////////////////////////
	// operand capture
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (start) begin
			a_q <= issue.a;
			b_q <= issue.b;
		end
	end

	// low word only
	assign full_product = a_q * b_q;
	assign product = full_product[`WORD_WIDTH-1:0];

	////////////////////////////////////////////////////////////////////////////
	// product pipeline
	////////////////////////////////////////////////////////////////////////////

	// no stall, every stage moves on every edge
	always_ff @(posedge clk) begin
		stage[0] <= product;
		for (int i = 1; i < STAGES; i++) begin
			stage[i] <= stage[i - 1];
		end
	end

	// last stage lines up with the booked beat
	assign result = stage[STAGES - 1];

endmodule

// ==== rtl/cdb_scheduler.sv ====
`timescale 1ns/1ps
`include "wb_defines.svh"

module cdb_scheduler (
	input logic clk,
	input logic reset,
	input logic flush,
	input issue_pkg::issue_req_t issue,
	output logic issue_ready,
	output logic alu_start,
	output logic mul_start,
	input cdb_pkg::cdb_t in_req,
	output logic in_ready,
	input issue_pkg::word_t alu_result,
	input issue_pkg::word_t mul_result,
	output cdb_pkg::cdb_t cdb
);
	import issue_pkg::*;
	import cdb_pkg::*;

	localparam int DEPTH = `MUL_LATENCY;
	localparam int TOP = DEPTH - 1;

	// slot 0 is the beat on the bus this cycle
	rsv_slot_t rsv [DEPTH];
	rsv_slot_t rsv_next [DEPTH];

	op_t op;
	logic is_mul;
	logic alu_slot_free;
	logic in_accept;
	rsv_slot_t head;
	word_t unit_data;

	////////////////////////////////////////////////////////////////////////////
	// accept
	////////////////////////////////////////////////////////////////////////////

	assign op = issue.op;
	assign is_mul = op == `OP_MUL;

	// slot 1 drops into slot 0 at the next edge
	assign alu_slot_free = !rsv[1].valid;

	// multiply always fits, its top slot is free after every shift
	always_comb begin
		if (flush) begin
			issue_ready = 1'b0;
		end else if (is_mul) begin
			issue_ready = 1'b1;
		end else begin
			issue_ready = alu_slot_free;
		end
	end

	assign alu_start = issue.valid && issue_ready && !is_mul;
	assign mul_start = issue.valid && issue_ready && is_mul;

	////////////////////////////////////////////////////////////////////////////
	// reservation shift register
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < TOP; i++) begin
			rsv_next[i] = rsv[i + 1];
		end

		// multiply books the far end
		rsv_next[TOP].valid = mul_start;
		rsv_next[TOP].tag = issue.tag;
		rsv_next[TOP].src = `SRC_MUL;

		// alu lands in slot 0, only taken when slot 1 was empty
		if (alu_start) begin
			rsv_next[0].valid = 1'b1;
			rsv_next[0].tag = issue.tag;
			rsv_next[0].src = `SRC_ALU;
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < DEPTH; i++) begin
			rsv[i].tag <= rsv_next[i].tag;
			rsv[i].src <= rsv_next[i].src;
			if (reset || flush) begin
				rsv[i].valid <= 1'b0;
			end else begin
				rsv[i].valid <= rsv_next[i].valid;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// bus
	////////////////////////////////////////////////////////////////////////////

	assign head = rsv[0];

	// external write only in an unbooked cycle
	assign in_ready = !head.valid;
	assign in_accept = in_req.valid && in_ready;

	assign unit_data = (head.src == `SRC_MUL) ? mul_result : alu_result;

	always_comb begin
		if (head.valid) begin
			cdb.valid = 1'b1;
			cdb.tag = head.tag;
			cdb.data = unit_data;
		end else begin
			cdb.valid = in_accept;
			cdb.tag = in_req.tag;
			cdb.data = in_req.data;
		end
	end

endmodule

// ==== rtl/wb_core_top.sv ====
`timescale 1ns/1ps

module wb_core_top (
	input logic clk,
	input logic reset,
	input logic flush,
	input issue_pkg::issue_req_t issue,
	output logic issue_ready,
	input cdb_pkg::cdb_t in_req,
	output logic in_ready,
	output cdb_pkg::cdb_t cdb
);
	import issue_pkg::*;

	logic alu_start;
	logic mul_start;
	word_t alu_result;
	word_t mul_result;

	////////////////////////////////////////////////////////////////////////////
	// execution units
	////////////////////////////////////////////////////////////////////////////

	int_alu u_int_alu (
		.clk(clk),
		.start(alu_start),
		.issue(issue),
		.result(alu_result)
	);

	mul_pipe u_mul_pipe (
		.clk(clk),
		.start(mul_start),
		.issue(issue),
		.result(mul_result)
	);

	////////////////////////////////////////////////////////////////////////////
	// write-back
	////////////////////////////////////////////////////////////////////////////

	cdb_scheduler u_cdb_scheduler (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.issue(issue),
		.issue_ready(issue_ready),
		.alu_start(alu_start),
		.mul_start(mul_start),
		.in_req(in_req),
		.in_ready(in_ready),
		.alu_result(alu_result),
		.mul_result(mul_result),
		.cdb(cdb)
	);

endmodule

// ==== testbench/wb_core_tb.sv ====
`timescale 1ns/1ps
`include "wb_defines.svh"

module wb_core_tb;
	import issue_pkg::*;
	import cdb_pkg::*;

	localparam int STIM_CYCLES = 2000;
	localparam int DRAIN_CYCLES = `MUL_LATENCY + 4;
	localparam int RESET_CYCLES = 5;
	localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES + 100;

	// one beat the model expects on the bus
	typedef struct packed {
		int due;
		tag_t tag;
		word_t data;
	} beat_t;

	logic clk;
	logic reset;
	logic flush;
	issue_req_t issue;
	logic issue_ready;
	cdb_t in_req;
	logic in_ready;
	cdb_t cdb;

	logic [31:0] lfsr_state;
	beat_t pending[$];
	int now;
	int cycle_count = 0;
	logic issue_hold;
	logic in_hold;

	wb_core_top u_dut (
		.clk(clk),
		.reset(reset),
		.flush(flush),
		.issue(issue),
		.issue_ready(issue_ready),
		.in_req(in_req),
		.in_ready(in_ready),
		.cdb(cdb)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			fail_run();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_run();
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("Mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
			fail_run();
		end
	endtask

	// fibonacci lfsr, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		logic feedback;
		value = '0;
		for (int i = 0; i < count; i++) begin
			feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	function automatic word_t expected_result(input op_t op, input word_t a, input word_t b);
		logic signed [`WORD_WIDTH-1:0] sa;
		logic signed [`WORD_WIDTH-1:0] sb;
		logic [2*`WORD_WIDTH-1:0] wide;
		sa = a;
		sb = b;
		wide = {{`WORD_WIDTH{1'b0}}, a} * {{`WORD_WIDTH{1'b0}}, b};
		case (op)
			`OP_ADD: return a + b;
			`OP_SUB: return a - b;
			`OP_AND: return a & b;
			`OP_OR: return a | b;
			`OP_XOR: return a ^ b;
			`OP_SLT: return (sa < sb) ? word_t'(1) : word_t'(0);
			`OP_MUL: return wide[`WORD_WIDTH-1:0];
			default: return '0;
		endcase
	endfunction

	// a refused request is held until accepted
	task automatic drive_stimulus(input bit active);
		issue_req_t next_issue;
		cdb_t next_in;
		logic [31:0] r;
		next_issue = issue;
		next_in = in_req;
		if (!active) begin
			next_issue.valid = 1'b0;
			next_in.valid = 1'b0;
			flush <= 1'b0;
		end else begin
			if (!issue_hold) begin
				r = random_bits(2);
				next_issue.valid = r[1:0] != 2'b00;
				r = random_bits(`OP_WIDTH);
				next_issue.op = (r[2:0] == 3'd7) ? `OP_MUL : r[2:0];
				r = random_bits(`TAG_WIDTH);
				next_issue.tag = r[`TAG_WIDTH-1:0];
				next_issue.a = random_bits(`WORD_WIDTH);
				next_issue.b = random_bits(`WORD_WIDTH);
			end
			if (!in_hold) begin
				r = random_bits(1);
				next_in.valid = r[0];
				r = random_bits(`TAG_WIDTH);
				next_in.tag = r[`TAG_WIDTH-1:0];
				next_in.data = random_bits(`WORD_WIDTH);
			end
			r = random_bits(5);
			flush <= r[4:0] == 5'd0;
		end
		issue <= next_issue;
		in_req <= next_in;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// reference model, sampled mid cycle
	////////////////////////////////////////////////////////////////////////////

	task automatic check_cycle();
		beat_t kept[$];
		beat_t due_now;
		beat_t booked;
		int due_count;
		logic busy_next;
		logic ready_exp;
		due_count = 0;
		busy_next = 1'b0;
		due_now = '0;
		foreach (pending[i]) begin
			if (pending[i].due == now) begin
				due_count++;
				due_now = pending[i];
			end else begin
				kept.push_back(pending[i]);
				if (pending[i].due == now + 1) begin
					busy_next = 1'b1;
				end
			end
		end

		// alu lands next cycle, so a multiply due then blocks it
		if (flush) begin
			ready_exp = 1'b0;
		end else if (issue.op == `OP_MUL) begin
			ready_exp = 1'b1;
		end else begin
			ready_exp = !busy_next;
		end
		check_value("issue_ready", 32'(ready_exp), 32'(issue_ready));
		check_value("in_ready", 32'(due_count == 0), 32'(in_ready));

		if (due_count == 1) begin
			check_value("cdb.valid", 32'd1, 32'(cdb.valid));
			check_value("cdb.tag", 32'(due_now.tag), 32'(cdb.tag));
			check_value("cdb.data", due_now.data, cdb.data);
		end else if (in_req.valid) begin
			check_value("cdb.valid", 32'd1, 32'(cdb.valid));
			check_value("cdb.tag", 32'(in_req.tag), 32'(cdb.tag));
			check_value("cdb.data", in_req.data, cdb.data);
		end else begin
			check_value("cdb.valid", 32'd0, 32'(cdb.valid));
		end

		pending = kept;
		if (flush) begin
			pending.delete();
		end else if (issue.valid && ready_exp) begin
			booked.due = (issue.op == `OP_MUL) ? now + `MUL_LATENCY : now + 1;
			booked.tag = issue.tag;
			booked.data = expected_result(issue.op, issue.a, issue.b);
			pending.push_back(booked);
		end
		issue_hold = issue.valid && !issue_ready;
		in_hold = in_req.valid && !in_ready;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		issue_req_t mul_probe;
		lfsr_state = 32'd76936;
		now = 0;
		issue_hold = 1'b0;
		in_hold = 1'b0;
		mul_probe = '0;
		mul_probe.op = `OP_MUL;
		reset <= 1'b1;
		flush <= 1'b0;
		issue <= '0;
		in_req <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		// idle bus and both classes ready out of reset
		@(negedge clk);
		check_value("cdb.valid", 32'd0, 32'(cdb.valid));
		check_value("in_ready", 32'd1, 32'(in_ready));
		check_value("issue_ready", 32'd1, 32'(issue_ready));
		@(posedge clk);
		issue <= mul_probe;
		@(negedge clk);
		check_value("issue_ready", 32'd1, 32'(issue_ready));

		for (int n = 0; n < STIM_CYCLES + DRAIN_CYCLES; n++) begin
			@(posedge clk);
			drive_stimulus(n < STIM_CYCLES);
			@(negedge clk);
			check_cycle();
			now++;
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/issue_pkg.sv
rtl/cdb_pkg.sv
rtl/int_alu.sv
rtl/mul_pipe.sv
rtl/cdb_scheduler.sv
rtl/wb_core_top.sv
testbench/wb_core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the write-back testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	--top-module wb_core_tb -Mdir "$build_dir" -o wb_core_tb -f tb.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

"./$build_dir/wb_core_tb" > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

# the log decides pass or fail
if grep -qx "Result: PASSED" "$log"; then
	exit 0
fi
echo "pass line not found in $log"
exit 1
